//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_warp_decode -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation did not pass"; exit 1; }

//--- sources.f
src/decode_pkg.sv
src/op_decoder.sv
src/imm_gen.sv
src/stage_buffer.sv
src/warp_decode.sv
testbench/tb_warp_decode.sv

//--- src/decode_pkg.sv
// Shared RV32 decode encodings; operation codes are 4 bits and are meaningful only with ex_type
package decode_pkg;

    localparam int XLEN     = 32;
    localparam int REG_BITS = 5;
    localparam int OP_BITS  = 4;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef enum logic {
        ALU_ARITH  = 1'b0,
        ALU_BRANCH = 1'b1
    } alu_xtype_e;

    // Selects the bit-field layout in imm_gen
    typedef enum logic [3:0] {
        IMM_NONE = 4'd0,
        IMM_I    = 4'd1,
        IMM_ISH  = 4'd2,
        IMM_S    = 4'd3,
        IMM_B    = 4'd4,
        IMM_U    = 4'd5,
        IMM_J    = 4'd6,
        IMM_FOUR = 4'd7,
        IMM_CSR  = 4'd8
    } imm_fmt_e;

    // ALU arithmetic ops
    localparam logic [OP_BITS-1:0] ALU_ADD   = 4'd0;
    localparam logic [OP_BITS-1:0] ALU_SUB   = 4'd1;
    localparam logic [OP_BITS-1:0] ALU_SLL   = 4'd2;
    localparam logic [OP_BITS-1:0] ALU_SLT   = 4'd3;
    localparam logic [OP_BITS-1:0] ALU_SLTU  = 4'd4;
    localparam logic [OP_BITS-1:0] ALU_XOR   = 4'd5;
    localparam logic [OP_BITS-1:0] ALU_SRL   = 4'd6;
    localparam logic [OP_BITS-1:0] ALU_SRA   = 4'd7;
    localparam logic [OP_BITS-1:0] ALU_OR    = 4'd8;
    localparam logic [OP_BITS-1:0] ALU_AND   = 4'd9;
    localparam logic [OP_BITS-1:0] ALU_LUI   = 4'd10;
    localparam logic [OP_BITS-1:0] ALU_AUIPC = 4'd11;

    // ALU branch ops, including the system returns
    localparam logic [OP_BITS-1:0] BR_EQ     = 4'd0;
    localparam logic [OP_BITS-1:0] BR_NE     = 4'd1;
    localparam logic [OP_BITS-1:0] BR_LT     = 4'd2;
    localparam logic [OP_BITS-1:0] BR_GE     = 4'd3;
    localparam logic [OP_BITS-1:0] BR_LTU    = 4'd4;
    localparam logic [OP_BITS-1:0] BR_GEU    = 4'd5;
    localparam logic [OP_BITS-1:0] BR_JAL    = 4'd6;
    localparam logic [OP_BITS-1:0] BR_JALR   = 4'd7;
    localparam logic [OP_BITS-1:0] BR_ECALL  = 4'd8;
    localparam logic [OP_BITS-1:0] BR_EBREAK = 4'd9;
    localparam logic [OP_BITS-1:0] BR_URET   = 4'd10;
    localparam logic [OP_BITS-1:0] BR_SRET   = 4'd11;
    localparam logic [OP_BITS-1:0] BR_MRET   = 4'd12;

    // SFU ops; CSR ops are consecutive in func3 order
    localparam logic [OP_BITS-1:0] SFU_TMC    = 4'd0;
    localparam logic [OP_BITS-1:0] SFU_WSPAWN = 4'd1;
    localparam logic [OP_BITS-1:0] SFU_SPLIT  = 4'd2;
    localparam logic [OP_BITS-1:0] SFU_JOIN   = 4'd3;
    localparam logic [OP_BITS-1:0] SFU_BAR    = 4'd4;
    localparam logic [OP_BITS-1:0] SFU_PRED   = 4'd5;
    localparam logic [OP_BITS-1:0] SFU_CSRRW  = 4'd6;
    localparam logic [OP_BITS-1:0] SFU_CSRRS  = 4'd7;
    localparam logic [OP_BITS-1:0] SFU_CSRRC  = 4'd8;

    // Loads are {0, func3}, stores {1, func3}
    localparam logic [OP_BITS-1:0] LSU_FENCE = 4'd15;

    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_L     = 7'b0000011;
    localparam logic [6:0] OPC_S     = 7'b0100011;
    localparam logic [6:0] OPC_FENCE = 7'b0001111;
    localparam logic [6:0] OPC_SYS   = 7'b1110011;
    localparam logic [6:0] OPC_EXT1  = 7'b0001011;

    // CSR ops: imm[11:0] is the address, imm[16:12] the zimm
    typedef struct packed {
        alu_xtype_e       xtype;
        logic             use_pc;
        logic             use_imm;
        logic             is_store;
        logic             is_neg;
        logic [XLEN-1:0]  imm;
    } op_args_t;

endpackage

//--- src/imm_gen.sv
// Immediate is only valid for the format picked by op_decoder; CSR packing is unsigned
module imm_gen import decode_pkg::*; (
    input  logic [31:0]     instr,
    input  imm_fmt_e        imm_fmt,
    output logic [XLEN-1:0] imm
);

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_ISH: begin
                // Shift amount only, func7 bits are not part of it
                imm = {27'b0, instr[24:20]};
            end
            IMM_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            IMM_FOUR: begin
                // Return address offset for system ops
                imm = 32'd4;
            end
            IMM_CSR: begin
                // zimm above the 12-bit CSR address
                imm = {15'b0, instr[19:15], instr[31:20]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- src/op_decoder.sv
// RV32I and warp control only; unlisted encodings give ALU ADD, no registers, no stall
module op_decoder import decode_pkg::*; (
    input  logic [31:0]         instr,
    output ex_type_e            ex_type,
    output logic [OP_BITS-1:0]  op_type,
    output op_args_t            args,
    output imm_fmt_e            imm_fmt,
    output logic [REG_BITS-1:0] rd,
    output logic [REG_BITS-1:0] rs1,
    output logic [REG_BITS-1:0] rs2,
    output logic                wb,
    output logic                is_wstall
);

    // Highest floating-point CSR address
    localparam logic [11:0] FCSR_ADDR = 12'h003;

    logic [6:0]         opcode;
    logic [2:0]         func3;
    logic [6:0]         func7;
    logic [11:0]        u_12;
    logic [4:0]         rd_f;
    logic [4:0]         rs1_f;
    logic [4:0]         rs2_f;
    logic               is_itype_sh;
    logic [OP_BITS-1:0] alu_op;
    logic [OP_BITS-1:0] br_op;
    logic               br_known;
    logic [OP_BITS-1:0] sys_op;
    logic               sys_known;
    logic               use_rd;
    logic               use_rs1;
    logic               use_rs2;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign u_12   = instr[31:20];
    assign rd_f   = instr[11:7];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];

    // SLLI and SRLI/SRAI carry a shift amount
    assign is_itype_sh = func3[0] && !func3[1];

    always_comb begin
        case (func3)
            3'h0: alu_op = (opcode == OPC_R && func7[5]) ? ALU_SUB : ALU_ADD;
            3'h1: alu_op = ALU_SLL;
            3'h2: alu_op = ALU_SLT;
            3'h3: alu_op = ALU_SLTU;
            3'h4: alu_op = ALU_XOR;
            3'h5: alu_op = func7[5] ? ALU_SRA : ALU_SRL;
            3'h6: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        br_known = 1'b1;
        case (func3)
            3'h0: br_op = BR_EQ;
            3'h1: br_op = BR_NE;
            3'h4: br_op = BR_LT;
            3'h5: br_op = BR_GE;
            3'h6: br_op = BR_LTU;
            3'h7: br_op = BR_GEU;
            default: begin
                br_op    = BR_EQ;
                br_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        sys_known = 1'b1;
        case (u_12)
            12'h000: sys_op = BR_ECALL;
            12'h001: sys_op = BR_EBREAK;
            12'h002: sys_op = BR_URET;
            12'h102: sys_op = BR_SRET;
            12'h302: sys_op = BR_MRET;
            default: begin
                sys_op    = BR_ECALL;
                sys_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        ex_type   = EX_ALU;
        op_type   = ALU_ADD;
        args      = '0;
        imm_fmt   = IMM_NONE;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;

        case (opcode)
            OPC_I: begin
                op_type      = alu_op;
                args.use_imm = 1'b1;
                imm_fmt      = is_itype_sh ? IMM_ISH : IMM_I;
                use_rd       = 1'b1;
                use_rs1      = 1'b1;
            end
            OPC_R: begin
                op_type = alu_op;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                op_type      = opcode[5] ? ALU_LUI : ALU_AUIPC;
                args.use_pc  = !opcode[5];
                args.use_imm = 1'b1;
                imm_fmt      = IMM_U;
                use_rd       = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                op_type      = opcode[3] ? BR_JAL : BR_JALR;
                args.xtype   = ALU_BRANCH;
                args.use_pc  = opcode[3];
                args.use_imm = 1'b1;
                imm_fmt      = opcode[3] ? IMM_J : IMM_I;
                use_rd       = 1'b1;
                use_rs1      = !opcode[3];
                is_wstall    = 1'b1;
            end
            OPC_B: begin
                if (br_known) begin
                    op_type      = br_op;
                    args.xtype   = ALU_BRANCH;
                    args.use_pc  = 1'b1;
                    args.use_imm = 1'b1;
                    imm_fmt      = IMM_B;
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    is_wstall    = 1'b1;
                end
            end
            OPC_L, OPC_S: begin
                ex_type       = EX_LSU;
                op_type       = {opcode[5], func3};
                args.is_store = opcode[5];
                imm_fmt       = opcode[5] ? IMM_S : IMM_I;
                use_rd        = !opcode[5];
                use_rs1       = 1'b1;
                use_rs2       = opcode[5];
            end
            OPC_FENCE: begin
                ex_type = EX_LSU;
                op_type = LSU_FENCE;
            end
            OPC_SYS: begin
                if (func3[1:0] != 2'b00) begin
                    ex_type      = EX_SFU;
                    op_type      = SFU_CSRRW + OP_BITS'(func3[1:0] - 2'd1);
                    args.use_imm = func3[2];
                    imm_fmt      = IMM_CSR;
                    use_rd       = 1'b1;
                    use_rs1      = !func3[2];
                    // Only FPU CSRs hold the warp
                    is_wstall    = (u_12 <= FCSR_ADDR);
                end else if (func3 == 3'b000 && sys_known) begin
                    op_type      = sys_op;
                    args.xtype   = ALU_BRANCH;
                    args.use_pc  = 1'b1;
                    args.use_imm = 1'b1;
                    imm_fmt      = IMM_FOUR;
                    use_rd       = 1'b1;
                    is_wstall    = 1'b1;
                end
            end
            OPC_EXT1: begin
                if (func7 == 7'h00 && func3 <= 3'd5) begin
                    ex_type   = EX_SFU;
                    op_type   = SFU_TMC + OP_BITS'(func3);
                    use_rs1   = 1'b1;
                    is_wstall = 1'b1;
                    // WSPAWN, BAR and PRED read rs2
                    use_rs2   = (func3 == 3'd1) || (func3 == 3'd4) || (func3 == 3'd5);
                    if (func3 == 3'd2) begin
                        use_rd      = 1'b1;
                        args.is_neg = rs2_f[0];
                    end
                    if (func3 == 3'd5) begin
                        args.is_neg = rd_f[0];
                    end
                end
            end
            default: ;
        endcase
    end

    assign rd  = use_rd  ? rd_f  : '0;
    assign rs1 = use_rs1 ? rs1_f : '0;
    assign rs2 = use_rs2 ? rs2_f : '0;

    // x0 writes are dropped here
    assign wb = use_rd && (rd != '0);

    // LSU ops never resolve control flow
    always_comb begin
        assert (!(is_wstall && ex_type == EX_LSU))
            else $error("op_decoder: warp stall on LSU op, instr 0x%08h", instr);
    end

endmodule

//--- src/stage_buffer.sv
// One-entry buffer; ready_in depends combinationally on ready_out, so no bubble at full rate
module stage_buffer #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid_in,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic                  ready_in,
    output logic                  valid_out,
    output logic [DATA_WIDTH-1:0] data_out,
    input  logic                  ready_out
);

    logic                  full;
    logic [DATA_WIDTH-1:0] payload;

    // Accept while empty or while the held item leaves
    assign ready_in = !full || ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (ready_in) begin
            full <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && ready_in) begin
            payload <= data_in;
        end
    end

    assign valid_out = full;
    assign data_out  = payload;

    // Stalled output holds until taken
    property p_hold_when_stalled;
        @(posedge clk) disable iff (reset)
            (valid_out && !ready_out) |=> (valid_out && $stable(data_out));
    endproperty

    a_hold_when_stalled: assert property (p_hold_when_stalled)
        else $error("stage_buffer: output changed while stalled");

endmodule

//--- src/warp_decode.sv
// Decode stage for RV32 warps; NUM_WARPS must be at least 2 so the warp id has a bit
module warp_decode import decode_pkg::*; #(
    parameter int NUM_WARPS   = 4,
    parameter int NUM_THREADS = 4,
    parameter int UUID_WIDTH  = 8,
    localparam int WID_WIDTH  = $clog2(NUM_WARPS)
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    input  logic [UUID_WIDTH-1:0]  fetch_uuid,
    input  logic [WID_WIDTH-1:0]   fetch_wid,
    input  logic [NUM_THREADS-1:0] fetch_tmask,
    input  logic [XLEN-1:0]        fetch_pc,
    input  logic [31:0]            fetch_instr,

    output logic                   decode_valid,
    input  logic                   decode_ready,
    output logic [UUID_WIDTH-1:0]  decode_uuid,
    output logic [WID_WIDTH-1:0]   decode_wid,
    output logic [NUM_THREADS-1:0] decode_tmask,
    output logic [XLEN-1:0]        decode_pc,
    output ex_type_e               decode_ex_type,
    output logic [OP_BITS-1:0]     decode_op_type,
    output op_args_t               decode_op_args,
    output logic                   decode_wb,
    output logic [REG_BITS-1:0]    decode_rd,
    output logic [REG_BITS-1:0]    decode_rs1,
    output logic [REG_BITS-1:0]    decode_rs2,

    output logic                   sched_valid,
    output logic [WID_WIDTH-1:0]   sched_wid,
    output logic                   sched_is_wstall
);

    localparam int DATA_WIDTH = UUID_WIDTH + WID_WIDTH + NUM_THREADS + XLEN
                              + $bits(ex_type_e) + OP_BITS + $bits(op_args_t)
                              + 1 + 3 * REG_BITS;

    ex_type_e                 dec_ex_type;
    logic [OP_BITS-1:0]       dec_op_type;
    op_args_t                 dec_args;
    imm_fmt_e                 dec_imm_fmt;
    logic [REG_BITS-1:0]      dec_rd;
    logic [REG_BITS-1:0]      dec_rs1;
    logic [REG_BITS-1:0]      dec_rs2;
    logic                     dec_wb;
    logic                     dec_is_wstall;
    logic [XLEN-1:0]          dec_imm;
    op_args_t                 merged_args;
    logic [DATA_WIDTH-1:0]    buf_in;
    logic [DATA_WIDTH-1:0]    buf_out;
    logic [$bits(ex_type_e)-1:0] out_ex_type;

    op_decoder u_op_decoder (
        .instr     (fetch_instr),
        .ex_type   (dec_ex_type),
        .op_type   (dec_op_type),
        .args      (dec_args),
        .imm_fmt   (dec_imm_fmt),
        .rd        (dec_rd),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .wb        (dec_wb),
        .is_wstall (dec_is_wstall)
    );

    imm_gen u_imm_gen (
        .instr   (fetch_instr),
        .imm_fmt (dec_imm_fmt),
        .imm     (dec_imm)
    );

    always_comb begin
        merged_args     = dec_args;
        merged_args.imm = dec_imm;
    end

    assign buf_in = {fetch_uuid, fetch_wid, fetch_tmask, fetch_pc, dec_ex_type,
                     dec_op_type, merged_args, dec_wb, dec_rd, dec_rs1, dec_rs2};

    stage_buffer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_stage_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (fetch_valid),
        .data_in   (buf_in),
        .ready_in  (fetch_ready),
        .valid_out (decode_valid),
        .data_out  (buf_out),
        .ready_out (decode_ready)
    );

    assign {decode_uuid, decode_wid, decode_tmask, decode_pc, out_ex_type, decode_op_type,
            decode_op_args, decode_wb, decode_rd, decode_rs1, decode_rs2} = buf_out;
    assign decode_ex_type = ex_type_e'(out_ex_type);

    // Scheduler sees the stall in the same cycle the instruction is taken
    assign sched_valid     = fetch_valid && fetch_ready;
    assign sched_wid       = fetch_wid;
    assign sched_is_wstall = dec_is_wstall;

endmodule

//--- testbench/tb_warp_decode.sv
// Random RV32 and warp-control words; widths below assume NUM_WARPS=4, NUM_THREADS=4, UUID_WIDTH=8
module tb_warp_decode import decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [7:0]          uuid;
        logic [1:0]          wid;
        logic [3:0]          tmask;
        logic [XLEN-1:0]     pc;
        ex_type_e            ex_type;
        logic [OP_BITS-1:0]  op_type;
        op_args_t            args;
        logic                wb;
        logic [REG_BITS-1:0] rd;
        logic [REG_BITS-1:0] rs1;
        logic [REG_BITS-1:0] rs2;
    } exp_t;

    logic                clk;
    logic                reset;
    logic                fetch_valid;
    logic                fetch_ready;
    logic [7:0]          fetch_uuid;
    logic [1:0]          fetch_wid;
    logic [3:0]          fetch_tmask;
    logic [XLEN-1:0]     fetch_pc;
    logic [31:0]         fetch_instr;
    logic                decode_valid;
    logic                decode_ready;
    logic [7:0]          decode_uuid;
    logic [1:0]          decode_wid;
    logic [3:0]          decode_tmask;
    logic [XLEN-1:0]     decode_pc;
    ex_type_e            decode_ex_type;
    logic [OP_BITS-1:0]  decode_op_type;
    op_args_t            decode_op_args;
    logic                decode_wb;
    logic [REG_BITS-1:0] decode_rd;
    logic [REG_BITS-1:0] decode_rs1;
    logic [REG_BITS-1:0] decode_rs2;
    logic                sched_valid;
    logic [1:0]          sched_wid;
    logic                sched_is_wstall;

    integer seed;
    logic   ready_random;
    exp_t   cur_exp;
    logic   cur_stall;
    exp_t   exp_q[$];
    exp_t   head_exp;
    logic   have_head;
    exp_t   got;
    int     n;
    int     waits;

    warp_decode #(
        .NUM_WARPS   (4),
        .NUM_THREADS (4),
        .UUID_WIDTH  (8)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_uuid      (fetch_uuid),
        .fetch_wid       (fetch_wid),
        .fetch_tmask     (fetch_tmask),
        .fetch_pc        (fetch_pc),
        .fetch_instr     (fetch_instr),
        .decode_valid    (decode_valid),
        .decode_ready    (decode_ready),
        .decode_uuid     (decode_uuid),
        .decode_wid      (decode_wid),
        .decode_tmask    (decode_tmask),
        .decode_pc       (decode_pc),
        .decode_ex_type  (decode_ex_type),
        .decode_op_type  (decode_op_type),
        .decode_op_args  (decode_op_args),
        .decode_wb       (decode_wb),
        .decode_rd       (decode_rd),
        .decode_rs1      (decode_rs1),
        .decode_rs2      (decode_rs2),
        .sched_valid     (sched_valid),
        .sched_wid       (sched_wid),
        .sched_is_wstall (sched_is_wstall)
    );

    assign got = {decode_uuid, decode_wid, decode_tmask, decode_pc, decode_ex_type,
                  decode_op_type, decode_op_args, decode_wb, decode_rd, decode_rs1, decode_rs2};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("Error: %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic logic [OP_BITS-1:0] alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? ALU_SUB : ALU_ADD;
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return alt ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Expected decode of one word, with the scheduler stall as a side output
    function automatic exp_t model_decode(input logic [31:0] i, output logic stall);
        exp_t        e;
        logic [2:0]  f3;
        logic [11:0] csr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        rd_on;
        logic        rs1_on;
        logic        rs2_on;
        e = '0;
        f3 = i[14:12];
        csr = i[31:20];
        imm_i = $signed(i) >>> 20;
        imm_s = $signed({i[31:25], i[11:7], 20'b0}) >>> 20;
        imm_b = $signed({i[31], i[7], i[30:25], i[11:8], 1'b0, 19'b0}) >>> 19;
        imm_j = $signed({i[31], i[19:12], i[20], i[30:21], 1'b0, 11'b0}) >>> 11;
        rd_on = 1'b0;
        rs1_on = 1'b0;
        rs2_on = 1'b0;
        stall = 1'b0;
        e.ex_type = EX_ALU;
        case (i[6:0])
            OPC_I: begin
                e.op_type = alu_code(f3, f3 == 3'd5 && i[30]);
                e.args.use_imm = 1'b1;
                e.args.imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, i[24:20]} : imm_i;
                rd_on = 1'b1;
                rs1_on = 1'b1;
            end
            OPC_R: begin
                e.op_type = alu_code(f3, i[30]);
                rd_on = 1'b1;
                rs1_on = 1'b1;
                rs2_on = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                e.op_type = (i[6:0] == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                e.args.use_pc = (i[6:0] == OPC_AUIPC);
                e.args.use_imm = 1'b1;
                e.args.imm = {i[31:12], 12'b0};
                rd_on = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                e.op_type = (i[6:0] == OPC_JAL) ? BR_JAL : BR_JALR;
                e.args.xtype = ALU_BRANCH;
                e.args.use_pc = (i[6:0] == OPC_JAL);
                e.args.use_imm = 1'b1;
                e.args.imm = (i[6:0] == OPC_JAL) ? imm_j : imm_i;
                rd_on = 1'b1;
                rs1_on = (i[6:0] == OPC_JALR);
                stall = 1'b1;
            end
            OPC_B: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    // func3 4..7 map two codes lower
                    e.op_type = f3[2] ? OP_BITS'(f3) - 4'd2 : OP_BITS'(f3);
                    e.args.xtype = ALU_BRANCH;
                    e.args.use_pc = 1'b1;
                    e.args.use_imm = 1'b1;
                    e.args.imm = imm_b;
                    rs1_on = 1'b1;
                    rs2_on = 1'b1;
                    stall = 1'b1;
                end
            end
            OPC_L: begin
                e.ex_type = EX_LSU;
                e.op_type = {1'b0, f3};
                e.args.imm = imm_i;
                rd_on = 1'b1;
                rs1_on = 1'b1;
            end
            OPC_S: begin
                e.ex_type = EX_LSU;
                e.op_type = {1'b1, f3};
                e.args.is_store = 1'b1;
                e.args.imm = imm_s;
                rs1_on = 1'b1;
                rs2_on = 1'b1;
            end
            OPC_FENCE: begin
                e.ex_type = EX_LSU;
                e.op_type = LSU_FENCE;
            end
            OPC_SYS: begin
                if (f3[1:0] != 2'b00) begin
                    e.ex_type = EX_SFU;
                    case (f3[1:0])
                        2'd1: e.op_type = SFU_CSRRW;
                        2'd2: e.op_type = SFU_CSRRS;
                        default: e.op_type = SFU_CSRRC;
                    endcase
                    e.args.use_imm = f3[2];
                    e.args.imm = {15'b0, i[19:15], csr};
                    rd_on = 1'b1;
                    rs1_on = !f3[2];
                    stall = (csr <= 12'd3);
                end else if (f3 == 3'd0 &&
                             (csr inside {12'h000, 12'h001, 12'h002, 12'h102, 12'h302})) begin
                    e.op_type = csr[0] ? BR_EBREAK : csr[9] ? BR_MRET :
                                csr[8] ? BR_SRET : csr[1] ? BR_URET : BR_ECALL;
                    e.args.xtype = ALU_BRANCH;
                    e.args.use_pc = 1'b1;
                    e.args.use_imm = 1'b1;
                    e.args.imm = 32'd4;
                    rd_on = 1'b1;
                    stall = 1'b1;
                end
            end
            OPC_EXT1: begin
                if (i[31:25] == 7'd0 && f3 <= 3'd5) begin
                    e.ex_type = EX_SFU;
                    e.op_type = OP_BITS'(f3);
                    rs1_on = 1'b1;
                    rs2_on = (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd5);
                    rd_on = (f3 == 3'd2);
                    e.args.is_neg = (f3 == 3'd2) ? i[20] : (f3 == 3'd5) ? i[7] : 1'b0;
                    stall = 1'b1;
                end
            end
            default: ;
        endcase
        e.rd = rd_on ? i[11:7] : 5'd0;
        e.rs1 = rs1_on ? i[19:15] : 5'd0;
        e.rs2 = rs2_on ? i[24:20] : 5'd0;
        e.wb = rd_on && (i[11:7] != 5'd0);
        return e;
    endfunction

    // One template per instruction class, random fields elsewhere
    task automatic build_instr(output logic [31:0] w);
        logic [31:0] sel;
        logic [31:0] r;
        logic [2:0]  f3x;
        logic [11:0] addr;
        sel = $random(seed);
        r = $random(seed);
        f3x = {r[14], (r[13:12] == 2'b00) ? 2'b01 : r[13:12]};
        addr = r[15] ? {9'b0, r[22:20]} : r[31:20];
        case (sel[3:0])
            4'd0, 4'd1: w = {r[31:7], OPC_I};
            4'd2: w = {1'b0, r[31], 5'b0, r[24:7], OPC_R};
            4'd3: w = {r[31:7], r[0] ? OPC_LUI : OPC_AUIPC};
            4'd4: w = {r[31:7], OPC_JAL};
            4'd5: w = {r[31:15], 3'b000, r[11:7], OPC_JALR};
            4'd6: w = {r[31:7], OPC_B};
            4'd7: w = {r[31:7], OPC_L};
            4'd8: w = {r[31:7], OPC_S};
            4'd9: w = {r[31:7], OPC_FENCE};
            4'd10: w = {addr, r[19:15], f3x, r[11:7], OPC_SYS};
            4'd11: begin
                case (r[2:0])
                    3'd0: addr = 12'h000;
                    3'd1: addr = 12'h001;
                    3'd2: addr = 12'h002;
                    3'd3: addr = 12'h102;
                    default: addr = 12'h302;
                endcase
                w = {addr, 13'b0, OPC_SYS};
            end
            4'd12, 4'd13: w = {7'b0, r[24:15], r[14] ? {2'b10, r[12]} : r[14:12],
                               r[11:7], OPC_EXT1};
            default: w = r;
        endcase
        // Some x0 destinations
        if (sel[7:4] == 4'd0) begin
            w[11:7] = 5'd0;
        end
    endtask

    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #10;
        rnd = $random(seed);
        decode_ready = ready_random ? rnd[0] : 1'b1;
    endtask

    task automatic send_instr(input int idx);
        logic [31:0] w;
        logic [31:0] rnd;
        logic        stall;
        logic        taken;
        int          tries;
        exp_t        e;
        build_instr(w);
        rnd = $random(seed);
        e = model_decode(w, stall);
        e.uuid = idx[7:0];
        e.wid = rnd[1:0];
        e.tmask = rnd[5:2];
        e.pc = {16'h8000, rnd[31:18], 2'b00};
        fetch_valid = 1'b1;
        fetch_uuid = e.uuid;
        fetch_wid = e.wid;
        fetch_tmask = e.tmask;
        fetch_pc = e.pc;
        fetch_instr = w;
        cur_exp = e;
        cur_stall = stall;
        taken = 1'b0;
        tries = 0;
        while (!taken) begin
            @(negedge clk);
            taken = fetch_ready;
            tries++;
            if (!taken && tries > 100) begin
                stop_with_error("timeout waiting for fetch_ready");
            end
            next_cycle();
        end
    endtask

    // Scoreboard, pop before push so the head is always the oldest item
    always @(posedge clk) begin
        if (!reset) begin
            if (decode_valid && decode_ready) begin
                void'(exp_q.pop_front());
            end
            if (fetch_valid && fetch_ready) begin
                exp_q.push_back(cur_exp);
            end
        end
        have_head = (exp_q.size() != 0);
        head_exp = have_head ? exp_q[0] : '0;
    end

    a_decode_match: assert property (@(negedge clk) disable iff (reset)
        decode_valid |-> (have_head && got == head_exp))
        else stop_with_error($sformatf("decoded bundle expected %h got %h", head_exp, got));

    a_sched_pulse: assert property (@(negedge clk) disable iff (reset)
        (fetch_valid && fetch_ready) |->
            (sched_valid && sched_wid == fetch_wid && sched_is_wstall == cur_stall))
        else stop_with_error($sformatf("scheduler expected wid %0d stall %0b got %0d %0b",
                                       fetch_wid, cur_stall, sched_wid, sched_is_wstall));

    a_sched_idle: assert property (@(negedge clk) disable iff (reset)
        !(fetch_valid && fetch_ready) |-> !sched_valid)
        else stop_with_error("scheduler pulse without fetch transfer");

    a_full_blocks: assert property (@(negedge clk) disable iff (reset)
        (decode_valid && !decode_ready) |-> !fetch_ready)
        else stop_with_error("fetch_ready high while buffer full and stalled");

    a_stall_hold: assert property (@(negedge clk) disable iff (reset)
        (decode_valid && !decode_ready) |=> (decode_valid && $stable(got)))
        else stop_with_error("decoded bundle changed while stalled");

    initial begin
        seed = 22927;
        ready_random = 1'b0;
        cur_exp = '0;
        cur_stall = 1'b0;
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_uuid = '0;
        fetch_wid = '0;
        fetch_tmask = '0;
        fetch_pc = '0;
        fetch_instr = '0;
        decode_ready = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        assert (!decode_valid && !sched_valid && fetch_ready)
            else stop_with_error("outputs not idle after reset");
        next_cycle();
        // Full rate first, then random back-pressure
        for (n = 0; n < 400; n++) begin
            ready_random = (n >= 150);
            send_instr(n);
        end
        fetch_valid = 1'b0;
        ready_random = 1'b0;
        waits = 0;
        while (exp_q.size() != 0 || decode_valid) begin
            next_cycle();
            waits++;
            if (waits > 100) begin
                stop_with_error("timeout draining decoded items");
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule
